// File: logic/board_defines.svh
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// horizontal timing in pixel clocks.
`define H_VISIBLE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_TOTAL 800

// vertical timing in lines.
`define V_VISIBLE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_TOTAL 525

`define LED_STEP 4 // clocks between two moves of the running light.

`define TILE_BITS 6 // the tile is 2**TILE_BITS pixels on a side.

`endif

// File: logic/board_pkg.sv
package board_pkg;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef logic [9:0] coord_t;

    // segments are active low; bit 7 is the dot and stays dark.
    typedef logic [7:0] glyph_t;

    function automatic glyph_t hex_glyph(input logic [3:0] value);
        glyph_t glyph;
        case (value)
            4'h0: glyph = 8'hC0;
            4'h1: glyph = 8'hF9;
            4'h2: glyph = 8'hA4;
            4'h3: glyph = 8'hB0;
            4'h4: glyph = 8'h99;
            4'h5: glyph = 8'h92;
            4'h6: glyph = 8'h82;
            4'h7: glyph = 8'hF8;
            4'h8: glyph = 8'h80;
            4'h9: glyph = 8'h90;
            4'hA: glyph = 8'h88;
            4'hB: glyph = 8'h83;
            4'hC: glyph = 8'hC6;
            4'hD: glyph = 8'hA1;
            4'hE: glyph = 8'h86;
            default: glyph = 8'h8E;
        endcase
        return glyph;
    endfunction

endpackage

// File: logic/vga_if.sv
`timescale 1ns/1ps

interface vga_if;

    board_pkg::coord_t h_addr;
    board_pkg::coord_t v_addr;
    logic              rd_en;
    board_pkg::rgb_t   rd_data; // valid one clock after the address.

    modport ctrl (
        output h_addr,
        output v_addr,
        output rd_en,
        input  rd_data
    );

    modport mem (
        input  h_addr,
        input  v_addr,
        input  rd_en,
        output rd_data
    );

endinterface

// File: logic/lab_gates.sv
`timescale 1ns/1ps

module lab_gates (
    input  logic [7:0] a,
    input  logic [1:0] s,
    input  logic [2:0] x,
    input  logic       en,
    input  logic [7:0] ec_x,
    input  logic       ec_en,
    input  logic       alu_a,
    input  logic       alu_b,
    input  logic       alu_c,
    output logic [1:0] y,
    output logic [7:0] y_dec,
    output logic [2:0] ec_y,
    output logic       alu_s,
    output logic       alu_c_out
);

    // lane s occupies bits 2s+1 and 2s.
    assign y = a[{s, 1'b0} +: 2];

    assign y_dec = en ? (8'b1 << x) : 8'b0;

    always_comb begin
        ec_y = 3'd0;
        if (ec_en) begin
            for (int i = 0; i < 8; i++) begin
                if (ec_x[i]) begin
                    ec_y = 3'(i); // later bits win, so the top set bit is kept.
                end
            end
        end
    end

    assign alu_s     = alu_a ^ alu_b ^ alu_c;
    assign alu_c_out = (alu_a & alu_b) | (alu_c & (alu_a ^ alu_b));

endmodule

// File: logic/led_runner.sv
`timescale 1ns/1ps
`include "board_defines.svh"

module led_runner (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  sw,
    output logic [15:0] ledr
);

    localparam int STEP_W = $clog2(`LED_STEP);

    logic [STEP_W-1:0] step_cnt;
    logic [7:0]        run;
    logic [7:0]        sw_q;

    always_ff @(posedge clk) begin
        sw_q <= sw;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step_cnt <= '0;
            run      <= 8'h01;
        end else if (step_cnt == STEP_W'(`LED_STEP - 1)) begin
            step_cnt <= '0;
            run      <= {run[6:0], run[7]}; // move the light one place left.
        end else begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    assign ledr = {run, sw_q};

endmodule

// File: logic/seg_display.sv
`timescale 1ns/1ps

module seg_display (
    input  logic                clk,
    input  logic                rst,
    input  logic [2:0]          seg_x,
    output board_pkg::glyph_t   seg0,
    output board_pkg::glyph_t   seg1,
    output board_pkg::glyph_t   seg2,
    output board_pkg::glyph_t   seg3,
    output board_pkg::glyph_t   seg4,
    output board_pkg::glyph_t   seg5,
    output board_pkg::glyph_t   seg6,
    output board_pkg::glyph_t   seg7
);

    localparam board_pkg::glyph_t BLANK = 8'hFF; // all segments and the dot dark.

    board_pkg::glyph_t digit [8];

    for (genvar k = 0; k < 8; k++) begin : g_digit
        always_ff @(posedge clk) begin
            if (rst) begin
                digit[k] <= BLANK;
            end else begin
                // the 3-bit sum wraps the shown value to 0..7.
                digit[k] <= board_pkg::hex_glyph({1'b0, seg_x + 3'(k)});
            end
        end
    end

    assign seg0 = digit[0];
    assign seg1 = digit[1];
    assign seg2 = digit[2];
    assign seg3 = digit[3];
    assign seg4 = digit[4];
    assign seg5 = digit[5];
    assign seg6 = digit[6];
    assign seg7 = digit[7];

endmodule

// File: logic/vga_ctrl.sv
`timescale 1ns/1ps
`include "board_defines.svh"

module vga_ctrl (
    input  logic       clk,
    input  logic       rst,
    vga_if.ctrl        vid,
    output logic       hsync,
    output logic       vsync,
    output logic       valid,
    output logic [7:0] vga_r,
    output logic [7:0] vga_g,
    output logic [7:0] vga_b
);

    localparam board_pkg::coord_t H_LAST   = 10'(`H_TOTAL - 1);
    localparam board_pkg::coord_t V_LAST   = 10'(`V_TOTAL - 1);
    localparam board_pkg::coord_t H_VIS    = 10'(`H_VISIBLE);
    localparam board_pkg::coord_t V_VIS    = 10'(`V_VISIBLE);
    localparam board_pkg::coord_t HS_START = 10'(`H_VISIBLE + `H_FRONT);
    localparam board_pkg::coord_t HS_END   = 10'(`H_VISIBLE + `H_FRONT + `H_SYNC);
    localparam board_pkg::coord_t VS_START = 10'(`V_VISIBLE + `V_FRONT);
    localparam board_pkg::coord_t VS_END   = 10'(`V_VISIBLE + `V_FRONT + `V_SYNC);

    board_pkg::coord_t h;
    board_pkg::coord_t v;
    logic              visible;
    logic              h_in_sync;
    logic              v_in_sync;

    always_ff @(posedge clk) begin
        if (rst) begin
            h <= '0;
            v <= '0;
        end else if (h == H_LAST) begin
            h <= '0;
            v <= (v == V_LAST) ? '0 : v + 1'b1; // a new line starts each wrap of h.
        end else begin
            h <= h + 1'b1;
        end
    end

    assign visible   = (h < H_VIS) && (v < V_VIS);
    assign h_in_sync = (h >= HS_START) && (h < HS_END);
    assign v_in_sync = (v >= VS_START) && (v < VS_END);

    // the memory sees the live counters and answers one clock later.
    assign vid.h_addr = h;
    assign vid.v_addr = v;
    assign vid.rd_en  = visible;

    // the output stage lines up with the registered read data.
    always_ff @(posedge clk) begin
        if (rst) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            valid <= 1'b0;
        end else begin
            hsync <= ~h_in_sync;
            vsync <= ~v_in_sync;
            valid <= visible;
        end
    end

    assign vga_r = valid ? vid.rd_data.r : 8'h00;
    assign vga_g = valid ? vid.rd_data.g : 8'h00;
    assign vga_b = valid ? vid.rd_data.b : 8'h00;

endmodule

// File: logic/vmem.sv
`timescale 1ns/1ps
`include "board_defines.svh"

module vmem (
    input  logic                  clk,
    vga_if.mem                    vid,
    input  logic                  wr_en,
    input  logic [`TILE_BITS-1:0] wr_x,
    input  logic [`TILE_BITS-1:0] wr_y,
    input  board_pkg::rgb_t       wr_rgb
);

    localparam int DEPTH = 1 << (2 * `TILE_BITS);

    board_pkg::rgb_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[{wr_y, wr_x}] <= wr_rgb;
        end
    end

    // the tile repeats across the screen, so only the low address bits count.
    always_ff @(posedge clk) begin
        if (vid.rd_en) begin
            vid.rd_data <= mem[{vid.v_addr[`TILE_BITS-1:0], vid.h_addr[`TILE_BITS-1:0]}];
        end
    end

endmodule

// File: logic/board_top.sv
`timescale 1ns/1ps

module board_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  sw,
    input  logic [7:0]  a,
    input  logic [1:0]  s,
    input  logic [2:0]  x,
    input  logic        en,
    input  logic [7:0]  ec_x,
    input  logic        ec_en,
    input  logic [2:0]  seg_x,
    input  logic        alu_a,
    input  logic        alu_b,
    input  logic        alu_c,
    input  logic        wr_en,
    input  logic [5:0]  wr_x,
    input  logic [5:0]  wr_y,
    input  logic [23:0] wr_rgb,
    output logic [15:0] ledr,
    output logic [1:0]  y,
    output logic [7:0]  y_dec,
    output logic [2:0]  ec_y,
    output logic        alu_s,
    output logic        alu_c_out,
    output logic [7:0]  seg0,
    output logic [7:0]  seg1,
    output logic [7:0]  seg2,
    output logic [7:0]  seg3,
    output logic [7:0]  seg4,
    output logic [7:0]  seg5,
    output logic [7:0]  seg6,
    output logic [7:0]  seg7,
    output logic        VGA_CLK,
    output logic        VGA_HSYNC,
    output logic        VGA_VSYNC,
    output logic        VGA_BLANK_N,
    output logic [7:0]  VGA_R,
    output logic [7:0]  VGA_G,
    output logic [7:0]  VGA_B
);

    vga_if vid_bus ();

    assign VGA_CLK = clk; // the pixel clock is the system clock.

    lab_gates u_lab_gates (
        .a(a), .s(s), .x(x), .en(en), .ec_x(ec_x), .ec_en(ec_en),
        .alu_a(alu_a), .alu_b(alu_b), .alu_c(alu_c),
        .y(y), .y_dec(y_dec), .ec_y(ec_y), .alu_s(alu_s), .alu_c_out(alu_c_out)
    );

    led_runner u_led_runner (.clk(clk), .rst(rst), .sw(sw), .ledr(ledr));

    seg_display u_seg_display (
        .clk(clk), .rst(rst), .seg_x(seg_x),
        .seg0(seg0), .seg1(seg1), .seg2(seg2), .seg3(seg3),
        .seg4(seg4), .seg5(seg5), .seg6(seg6), .seg7(seg7)
    );

    vga_ctrl u_vga_ctrl (
        .clk(clk), .rst(rst), .vid(vid_bus.ctrl),
        .hsync(VGA_HSYNC), .vsync(VGA_VSYNC), .valid(VGA_BLANK_N),
        .vga_r(VGA_R), .vga_g(VGA_G), .vga_b(VGA_B)
    );

    vmem u_vmem (
        .clk(clk), .vid(vid_bus.mem),
        .wr_en(wr_en), .wr_x(wr_x), .wr_y(wr_y), .wr_rgb(wr_rgb)
    );

endmodule

// File: dv/board_top_tb.sv
`timescale 1ns/1ps
`include "board_defines.svh"

module board_top_tb;

    localparam int SEED        = 75501;
    localparam int GATE_CYCLES = 500;
    localparam int TILE        = 1 << `TILE_BITS;
    localparam int HS_START    = `H_VISIBLE + `H_FRONT;
    localparam int VS_START    = `V_VISIBLE + `V_FRONT;
    // tile fill, gate phase, two full frames and some slack.
    localparam int CYCLE_LIMIT = TILE * TILE + GATE_CYCLES + 2 * `H_TOTAL * `V_TOTAL + 2000;

    logic        clk, rst, en, ec_en, alu_a, alu_b, alu_c, wr_en;
    logic [7:0]  sw, a, ec_x, y_dec, VGA_R, VGA_G, VGA_B;
    logic [1:0]  s, y;
    logic [2:0]  x, seg_x, ec_y;
    logic [5:0]  wr_x, wr_y;
    logic [23:0] wr_rgb;
    logic [15:0] ledr;
    logic        alu_s, alu_c_out, VGA_CLK, VGA_HSYNC, VGA_VSYNC, VGA_BLANK_N;
    logic [7:0]  seg_out [8];

    logic [7:0]  glyph_tab [8] = '{8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8};
    logic [23:0] shadow [TILE * TILE]; // copy of the tile as written.
    logic [23:0] colour, pix;
    logic [7:0]  sw_prev;
    logic [2:0]  segx_prev;
    logic        started = 1'b0;
    logic        tile_ready = 1'b0;
    logic        vis_exp, hs_exp, vs_exp;
    int          mh = 0, mv = 0, vis_in_row = 0, rows_seen = 0;
    int          frames_done = 0, cycle_count = 0;

    board_top u_board_top (
        .*,
        .seg0(seg_out[0]), .seg1(seg_out[1]), .seg2(seg_out[2]), .seg3(seg_out[3]),
        .seg4(seg_out[4]), .seg5(seg_out[5]), .seg6(seg_out[6]), .seg7(seg_out[7])
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with the tests still running", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic verify_gates();
        logic [1:0] sum;
        logic [7:0] dec_exp;
        sum = 2'(alu_a) + 2'(alu_b) + 2'(alu_c);
        for (int j = 0; j < 8; j++) begin
            dec_exp[j] = en && (x == 3'(j)); // one output per code, all low when disabled.
        end
        check_value("y", 32'(y), 32'(2'(a >> (2 * s))));
        check_value("y_dec", 32'(y_dec), 32'(dec_exp));
        // floor of log2 gives the index of the top set bit.
        check_value("ec_y", 32'(ec_y),
                    (ec_en && ec_x != 0) ? 32'($clog2(int'(ec_x) + 1) - 1) : 32'h0);
        check_value("alu_s", 32'(alu_s), 32'(sum[0]));
        check_value("alu_c_out", 32'(alu_c_out), 32'(sum[1]));
    endtask

    // VGA_CLK follows clk through both halves of the period.
    always @(clk) begin
        #1;
        check_value("VGA_CLK", 32'(VGA_CLK), 32'(clk));
    end

    // the VGA outputs describe the counter state of the cycle before.
    always @(negedge clk) begin
        if (!rst) begin
            vis_exp = started && (mh < `H_VISIBLE) && (mv < `V_VISIBLE);
            hs_exp  = !(started && mh >= HS_START && mh < HS_START + `H_SYNC);
            vs_exp  = !(started && mv >= VS_START && mv < VS_START + `V_SYNC);
            pix     = vis_exp ? shadow[12'((mv % TILE) * TILE + mh % TILE)] : 24'h0;
            check_value("VGA_HSYNC", 32'(VGA_HSYNC), 32'(hs_exp));
            check_value("VGA_VSYNC", 32'(VGA_VSYNC), 32'(vs_exp));
            check_value("VGA_BLANK_N", 32'(VGA_BLANK_N), 32'(vis_exp));
            if (!vis_exp || frames_done == 1) begin
                check_value("VGA_R", 32'(VGA_R), 32'(pix[23:16]));
                check_value("VGA_G", 32'(VGA_G), 32'(pix[15:8]));
                check_value("VGA_B", 32'(VGA_B), 32'(pix[7:0]));
            end
            if (started) begin
                vis_in_row += int'(VGA_BLANK_N);
                if (mh == `H_TOTAL - 1) begin
                    if (vis_in_row != 0) begin
                        check_value("visible cycles in row", vis_in_row, `H_VISIBLE);
                        rows_seen++;
                    end
                    vis_in_row = 0;
                    mh = 0;
                    if (mv == `V_TOTAL - 1) begin
                        check_value("visible rows in frame", rows_seen, `V_VISIBLE);
                        check_value("tile_ready", 32'(tile_ready), 32'h1);
                        rows_seen = 0;
                        mv = 0;
                        frames_done++;
                    end else begin
                        mv++;
                    end
                end else begin
                    mh++;
                end
            end
            started = 1'b1;
        end
    end

    initial begin
        void'($urandom(SEED));
        rst = 1'b1;
        {sw, a, s, x, en, ec_x, ec_en, seg_x} = '0;
        {alu_a, alu_b, alu_c, wr_en, wr_x, wr_y, wr_rgb} = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        // in the first cycle after reset the digits are blank and only ledr[8] is lit.
        check_value("ledr", 32'(ledr), 32'h0100);
        for (int k = 0; k < 8; k++) begin
            check_value($sformatf("seg%0d", k), 32'(seg_out[k]), 32'hFF);
        end
        for (int i = 1; i <= GATE_CYCLES; i++) begin
            @(posedge clk);
            sw_prev = sw;
            segx_prev = seg_x;
            {a, s, x, en} <= 14'($urandom);
            {sw, seg_x, ec_en, alu_a, alu_b, alu_c} <= 15'($urandom);
            ec_x <= ($urandom % 8 == 0) ? 8'h00 : 8'($urandom); // zero gets its own share.
            @(negedge clk);
            verify_gates();
            check_value("ledr[7:0]", 32'(ledr[7:0]), 32'(sw_prev));
            check_value("ledr[15:8]", 32'(ledr[15:8]), 32'(8'h01 << ((i / `LED_STEP) % 8)));
            for (int k = 0; k < 8; k++) begin
                check_value($sformatf("seg%0d", k), 32'(seg_out[k]),
                            32'(glyph_tab[3'(segx_prev + 3'(k))]));
            end
        end
        for (int idx = 0; idx < TILE * TILE; idx++) begin
            @(posedge clk);
            colour = 24'($urandom);
            shadow[12'(idx)] = colour;
            wr_en  <= 1'b1;
            wr_x   <= 6'(idx % TILE);
            wr_y   <= 6'(idx / TILE);
            wr_rgb <= colour;
        end
        @(posedge clk);
        wr_en <= 1'b0;
        tile_ready = 1'b1;
        wait (frames_done == 2);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: board_top.f
+incdir+logic
logic/board_pkg.sv
logic/vga_if.sv
logic/lab_gates.sv
logic/led_runner.sv
logic/seg_display.sv
logic/vga_ctrl.sv
logic/vmem.sv
logic/board_top.sv
dv/board_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --timescale 1ns/1ps --top-module board_top_tb \
        -f board_top.f -o board_top_sim; then
    echo "build failed"
    exit 1
fi

./obj_dir/board_top_sim > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "TESTS FAILED" "$log"; then
    exit 1
fi
if [ "$sim_status" -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi
exit 0
